// File: Bender.yml
package:
  name: stash

sources:
  - verilog/StashPkg.sv
  - verilog/StashSlotIf.sv
  - verilog/StashSlot.sv
  - verilog/StashAllocator.sv
  - verilog/StashEvictSelect.sv
  - verilog/StashControl.sv
  - verilog/Stash.sv
  - target: test
    files:
      - testbench/Stash_checker.sv
      - testbench/StashTb.sv

// File: build.f
verilog/StashPkg.sv
verilog/StashSlotIf.sv
verilog/StashSlot.sv
verilog/StashAllocator.sv
verilog/StashEvictSelect.sv
verilog/StashControl.sv
verilog/Stash.sv
testbench/Stash_checker.sv
testbench/StashTb.sv

// File: testbench/StashTb.sv
/*
 * Table-driven path reads and writebacks for Stash, checked against a slot model.
 * Inputs change on the rising edge, outputs are sampled on the falling edge.
 */
`default_nettype none

module StashTb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int WaitLimit = 200;
	localparam int NumRows = 5;

	// One access, lane 0 is written first
	typedef struct packed {
		logic [2:0] count;
		StashPkg::pAddrT [StashPkg::TreeLevels-1:0] addr;
		StashPkg::leafT [StashPkg::TreeLevels-1:0] leaf;
		StashPkg::dataT [StashPkg::TreeLevels-1:0] data;
		StashPkg::leafT accessLeaf;
		logic randomReady;
		logic probeFull;
	} rowT;

	logic Clock;
	logic reset;
	StashPkg::leafT AccessLeaf;
	StashPkg::dataT WriteData;
	StashPkg::pAddrT WritePAddr;
	StashPkg::leafT WriteLeaf;
	logic WriteInValid;
	logic StartReadOperation;
	logic ReadOutReady;
	logic WriteInReady;
	logic BlockWriteComplete;
	StashPkg::dataT ReadData;
	StashPkg::pAddrT ReadPAddr;
	StashPkg::leafT ReadLeaf;
	logic ReadOutValid;
	logic BlockReadComplete;
	logic StashAlmostFull;
	logic StashOverflow;

	// Stash model
	logic mValid [StashPkg::StashSlots];
	StashPkg::pAddrT mAddr [StashPkg::StashSlots];
	StashPkg::leafT mLeaf [StashPkg::StashSlots];
	StashPkg::dataT mData [StashPkg::StashSlots];
	logic mOverflow;

	rowT scenario [NumRows];
	int errorCount;
	int failedTests;

	Stash u_Stash (.*);

	initial begin
		Clock = 1'b0;
		forever #10 Clock = ~Clock;
	end

	// ----------------------------------------------------------
	// Model helpers
	// ----------------------------------------------------------

	function automatic int occupancy();
		int n;
		n = 0;
		for (int i = 0; i < StashPkg::StashSlots; i++) begin
			if (mValid[i]) n++;
		end
		return n;
	endfunction

	function automatic int freeSlot();
		int found;
		found = -1;
		for (int i = 0; i < StashPkg::StashSlots; i++) begin
			if (found < 0 && !mValid[i]) found = i;
		end
		return found;
	endfunction

	// Lowest slot sharing the low level bits with the access leaf
	function automatic int eligibleSlot(int level, StashPkg::leafT accessLeaf);
		int found;
		int modulus;
		found = -1;
		modulus = 1 << level;
		for (int i = 0; i < StashPkg::StashSlots; i++) begin
			if (found < 0 && mValid[i] && (mLeaf[i] % modulus) == (accessLeaf % modulus)) begin
				found = i;
			end
		end
		return found;
	endfunction

	function automatic logic pickReady(logic randomReady);
		logic ready;
		if (randomReady) ready = ($urandom % 2) == 1;
		else ready = 1'b1;
		return ready;
	endfunction

	// ----------------------------------------------------------
	// Checks and reporting
	// ----------------------------------------------------------

	task automatic checkValue(string name, logic [31:0] got, logic [31:0] exp);
		if (got !== exp) begin
			$display("** Error: %s = 0x%0h, expected 0x%0h", name, got, exp);
			errorCount++;
		end
	endtask

	task automatic stopOnTimeout(string what);
		$display("Timeout: no %s within %0d cycles", what, WaitLimit);
		$display("Test FAILED");
		$finish;
	endtask

	task automatic reportTest(string name, int errorsBefore);
		if (errorCount == errorsBefore) begin
			$display("%s: passed", name);
		end else begin
			failedTests++;
			$display("%s: failed with %0d errors", name, errorCount - errorsBefore);
		end
	endtask

	// ----------------------------------------------------------
	// Stimulus tasks, each entered just after a rising edge
	// ----------------------------------------------------------

	task automatic applyReset();
		reset <= 1'b1;
		WriteInValid <= 1'b0;
		StartReadOperation <= 1'b0;
		ReadOutReady <= 1'b0;
		repeat (5) @(posedge Clock);
		reset <= 1'b0;
		for (int i = 0; i < StashPkg::StashSlots; i++) mValid[i] = 1'b0;
		mOverflow = 1'b0;
		@(negedge Clock);
		checkValue("ReadOutValid", ReadOutValid, 1'b0);
		checkValue("BlockWriteComplete", BlockWriteComplete, 1'b0);
		checkValue("BlockReadComplete", BlockReadComplete, 1'b0);
		checkValue("StashAlmostFull", StashAlmostFull, 1'b0);
		checkValue("StashOverflow", StashOverflow, 1'b0);
		checkValue("WriteInReady", WriteInReady, 1'b1);
		@(posedge Clock);
	endtask

	// Leaves WriteInValid high for back-to-back writes
	task automatic writeBlock(StashPkg::pAddrT addr, StashPkg::leafT leaf, StashPkg::dataT data);
		int waited;
		int slot;
		logic accepted;
		WriteInValid <= 1'b1;
		WritePAddr <= addr;
		WriteLeaf <= leaf;
		WriteData <= data;
		accepted = 1'b0;
		waited = 0;
		while (!accepted) begin
			@(negedge Clock);
			checkValue("StashAlmostFull", StashAlmostFull,
				occupancy() >= StashPkg::AlmostFullMark);
			checkValue("WriteInReady", WriteInReady, occupancy() < StashPkg::StashSlots);
			if (WriteInReady) begin
				accepted = 1'b1;
				checkValue("BlockWriteComplete", BlockWriteComplete, 1'b1);
			end else begin
				waited++;
				if (waited > WaitLimit) stopOnTimeout("write handshake");
			end
			@(posedge Clock);
		end
		// Dummy blocks are dropped
		slot = freeSlot();
		if (addr != '0 && slot >= 0) begin
			mValid[slot] = 1'b1;
			mAddr[slot] = addr;
			mLeaf[slot] = leaf;
			mData[slot] = data;
		end
	endtask

	// Real block offered to a full stash
	task automatic probeFull(StashPkg::pAddrT addr, StashPkg::leafT leaf, StashPkg::dataT data);
		WriteInValid <= 1'b1;
		WritePAddr <= addr;
		WriteLeaf <= leaf;
		WriteData <= data;
		repeat (3) begin
			@(negedge Clock);
			checkValue("WriteInReady", WriteInReady, 1'b0);
			checkValue("BlockWriteComplete", BlockWriteComplete, 1'b0);
			@(posedge Clock);
		end
		WriteInValid <= 1'b0;
		mOverflow = 1'b1;
	endtask

	task automatic runWriteback(StashPkg::leafT accessLeaf, logic randomReady);
		int waited;
		int slot;
		logic sent;
		StashPkg::pAddrT expAddr;
		StashPkg::leafT expLeaf;
		StashPkg::dataT expData;
		StartReadOperation <= 1'b1;
		ReadOutReady <= pickReady(randomReady);
		@(posedge Clock);
		StartReadOperation <= 1'b0;
		// Real block offered while the stash drains, must be refused
		WriteInValid <= 1'b1;
		WritePAddr <= 8'h6E;
		WriteLeaf <= accessLeaf;
		WriteData <= 16'hBEEF;
		if (occupancy() == StashPkg::StashSlots) mOverflow = 1'b1;
		// Leaf bucket first, root last
		for (int level = StashPkg::TreeLevels - 1; level >= 0; level--) begin
			slot = eligibleSlot(level, accessLeaf);
			expAddr = (slot >= 0) ? mAddr[slot] : '0;
			expLeaf = (slot >= 0) ? mLeaf[slot] : '0;
			expData = (slot >= 0) ? mData[slot] : '0;
			sent = 1'b0;
			waited = 0;
			while (!sent) begin
				@(negedge Clock);
				if (ReadOutValid) begin
					checkValue("ReadPAddr", ReadPAddr, expAddr);
					checkValue("ReadLeaf", ReadLeaf, expLeaf);
					checkValue("ReadData", ReadData, expData);
					checkValue("BlockReadComplete", BlockReadComplete, ReadOutReady);
					checkValue("WriteInReady", WriteInReady, 1'b0);
					checkValue("BlockWriteComplete", BlockWriteComplete, 1'b0);
					sent = ReadOutReady;
				end
				if (!sent) begin
					waited++;
					if (waited > WaitLimit) stopOnTimeout("writeback handshake");
				end
				@(posedge Clock);
				ReadOutReady <= pickReady(randomReady);
			end
			if (slot >= 0) mValid[slot] = 1'b0;
		end
		ReadOutReady <= 1'b0;
		WriteInValid <= 1'b0;
		// Back in idle, unsent blocks stay
		@(negedge Clock);
		checkValue("ReadOutValid", ReadOutValid, 1'b0);
		checkValue("StashAlmostFull", StashAlmostFull, occupancy() >= StashPkg::AlmostFullMark);
		checkValue("StashOverflow", StashOverflow, mOverflow);
		@(posedge Clock);
	endtask

	// Lanes packed lane 3 first, so the rightmost field is written first
	task automatic loadTable();
		// Real and dummy mix, root bucket gets a dummy
		scenario[0] = {3'd4, 32'h13_12_00_11, 16'h1_D_0_5, 64'hA004_A003_A002_A001,
			4'h5, 1'b0, 1'b0};
		// Every block finds a bucket, random back-pressure
		scenario[1] = {3'd4, 32'h24_23_22_21, 16'h3_A_6_2, 64'hB004_B003_B002_B001,
			4'h2, 1'b1, 1'b0};
		// Odd leaves against leaf 0 fit only the root, stash fills up
		scenario[2] = {3'd4, 32'h34_33_32_31, 16'h7_5_3_1, 64'hC004_C003_C002_C001,
			4'h0, 1'b0, 1'b0};
		scenario[3] = {3'd4, 32'h44_43_42_41, 16'hF_D_B_9, 64'hD004_D003_D002_D001,
			4'h0, 1'b1, 1'b0};
		scenario[4] = {3'd2, 32'h00_00_52_51, 16'h0_0_3_1, 64'h0000_0000_E002_E001,
			4'h0, 1'b0, 1'b1};
	endtask

	// ----------------------------------------------------------
	// Main sequence
	// ----------------------------------------------------------

	initial begin
		int errorsBefore;
		rowT row;
		void'($urandom(97322));
		reset = 1'b1;
		AccessLeaf = '0;
		WriteData = '0;
		WritePAddr = '0;
		WriteLeaf = '0;
		WriteInValid = 1'b0;
		StartReadOperation = 1'b0;
		ReadOutReady = 1'b0;
		errorCount = 0;
		failedTests = 0;
		loadTable();

		errorsBefore = errorCount;
		applyReset();
		reportTest("Reset state", errorsBefore);

		for (int r = 0; r < NumRows; r++) begin
			row = scenario[r];
			errorsBefore = errorCount;
			AccessLeaf <= row.accessLeaf;
			for (int b = 0; b < row.count; b++) begin
				writeBlock(row.addr[b], row.leaf[b], row.data[b]);
			end
			WriteInValid <= 1'b0;
			if (row.probeFull) probeFull(8'h5F, 4'h1, 16'hDEAD);
			runWriteback(row.accessLeaf, row.randomReady);
			reportTest($sformatf("Access %0d, leaf 0x%0h", r, row.accessLeaf), errorsBefore);
		end

		// Only reset clears the overflow flag
		errorsBefore = errorCount;
		applyReset();
		reportTest("Overflow cleared by reset", errorsBefore);

		$display("%0d tests run, %0d failed, %0d errors", NumRows + 2, failedTests, errorCount);
		if (errorCount == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: testbench/Stash_checker.sv
/*
 * Handshake and status assertions for Stash, bound into every instance.
 * Sampled on the rising clock and idle while reset is high.
 */
`default_nettype none

module Stash_checker (
	input wire Clock,
	input wire reset,
	input wire WritebackActive,
	input wire [StashPkg::SlotIndexWidth:0] Occupancy,
	input wire ReadOutValid,
	input wire ReadOutReady,
	input wire StashPkg::pAddrT ReadPAddr,
	input wire StashPkg::leafT ReadLeaf,
	input wire StashPkg::dataT ReadData,
	input wire StashOverflow
);

	timeunit 1ns;
	timeprecision 1ps;

	// No block lands in the stash while it drains
	assert property (@(posedge Clock) disable iff (reset)
		WritebackActive |=> (Occupancy <= $past(Occupancy)))
		else $error("block stored during writeback");

	// Stalled read block holds its fields
	assert property (@(posedge Clock) disable iff (reset)
		(ReadOutValid && !ReadOutReady) |=>
			($stable(ReadPAddr) && $stable(ReadLeaf) && $stable(ReadData)))
		else $error("read fields changed under back-pressure");

	// Sticky overflow
	assert property (@(posedge Clock) disable iff (reset)
		StashOverflow |=> StashOverflow)
		else $error("overflow flag fell without reset");

endmodule

bind Stash Stash_checker u_Checker (
	.Clock(Clock),
	.reset(reset),
	.WritebackActive(writebackActive),
	.Occupancy(u_Allocator.occupancy),
	.ReadOutValid(ReadOutValid),
	.ReadOutReady(ReadOutReady),
	.ReadPAddr(ReadPAddr),
	.ReadLeaf(ReadLeaf),
	.ReadData(ReadData),
	.StashOverflow(StashOverflow)
);

`default_nettype wire

// File: verilog/Stash.sv
/*
 * Path ORAM stash: eight slots, four-level path, one block per bucket.
 * No LLC return or evict ports and no position-map scan.
 */
`default_nettype none

module Stash (
	input wire Clock,
	input wire reset,
	input wire StashPkg::leafT AccessLeaf,
	input wire StashPkg::dataT WriteData,
	input wire StashPkg::pAddrT WritePAddr,
	input wire StashPkg::leafT WriteLeaf,
	input wire WriteInValid,
	input wire StartReadOperation,
	input wire ReadOutReady,
	output logic WriteInReady,
	output logic BlockWriteComplete,
	output StashPkg::dataT ReadData,
	output StashPkg::pAddrT ReadPAddr,
	output StashPkg::leafT ReadLeaf,
	output logic ReadOutValid,
	output logic BlockReadComplete,
	output logic StashAlmostFull,
	output logic StashOverflow
);

	logic pathReadActive;
	logic writebackActive;
	logic blockSent;
	StashPkg::levelT level;

	// One link per entry
	StashSlotIf slotIf[StashPkg::StashSlots] ();

	// ----------------------------------------------------------
	// Sequencing
	// ----------------------------------------------------------

	StashControl u_Control (
		.Clock(Clock),
		.reset(reset),
		.WriteInValid(WriteInValid),
		.WriteInReady(WriteInReady),
		.StartReadOperation(StartReadOperation),
		.BlockSent(blockSent),
		.PathReadActive(pathReadActive),
		.WritebackActive(writebackActive),
		.Level(level),
		.BlockWriteComplete(BlockWriteComplete),
		.ReadOutValid(ReadOutValid)
	);

	// ----------------------------------------------------------
	// Fill side, slot array, drain side
	// ----------------------------------------------------------

	StashAllocator u_Allocator (
		.Clock(Clock),
		.reset(reset),
		.PathReadActive(pathReadActive),
		.WritebackActive(writebackActive),
		.WriteData(WriteData),
		.WritePAddr(WritePAddr),
		.WriteLeaf(WriteLeaf),
		.WriteInValid(WriteInValid),
		.WriteInReady(WriteInReady),
		.StashAlmostFull(StashAlmostFull),
		.StashOverflow(StashOverflow),
		.Fill(slotIf)
	);

	for (genvar i = 0; i < StashPkg::StashSlots; i++) begin : gSlot
		StashSlot u_Slot (
			.Clock(Clock),
			.reset(reset),
			.Slot(slotIf[i])
		);
	end

	StashEvictSelect u_Select (
		.WritebackActive(writebackActive),
		.Level(level),
		.AccessLeaf(AccessLeaf),
		.ReadOutValid(ReadOutValid),
		.ReadOutReady(ReadOutReady),
		.ReadData(ReadData),
		.ReadPAddr(ReadPAddr),
		.ReadLeaf(ReadLeaf),
		.BlockReadComplete(BlockReadComplete),
		.BlockSent(blockSent),
		.Drain(slotIf)
	);

endmodule

`default_nettype wire

// File: verilog/StashAllocator.sv
/*
 * Places accepted real blocks in the lowest free slot; dummies are accepted and dropped.
 * Overflow is sticky and clears only on reset.
 */
`default_nettype none

module StashAllocator (
	input wire Clock,
	input wire reset,
	input wire PathReadActive,
	input wire WritebackActive,
	input wire StashPkg::dataT WriteData,
	input wire StashPkg::pAddrT WritePAddr,
	input wire StashPkg::leafT WriteLeaf,
	input wire WriteInValid,
	output logic WriteInReady,
	output logic StashAlmostFull,
	output logic StashOverflow,
	StashSlotIf.Fill Fill[StashPkg::StashSlots]
);

	logic [StashPkg::StashSlots-1:0] validVec;
	logic [StashPkg::StashSlots-1:0] loadVec;
	logic [StashPkg::SlotIndexWidth:0] occupancy;
	StashPkg::slotIndexT freeIdx;
	logic anyFree;
	logic idle;
	logic realBlock;
	logic accept;

	// ----------------------------------------------------------
	// Slot fan-out
	// ----------------------------------------------------------

	for (genvar i = 0; i < StashPkg::StashSlots; i++) begin : gSlot
		assign validVec[i] = Fill[i].Valid;
		assign Fill[i].Load = loadVec[i];
		// Fill block is broadcast, Load picks the target
		assign Fill[i].FillPAddr = WritePAddr;
		assign Fill[i].FillLeaf = WriteLeaf;
		assign Fill[i].FillData = WriteData;
	end

	// ----------------------------------------------------------
	// Free slot search and handshake
	// ----------------------------------------------------------

	// Downward scan so the lowest free slot wins
	always_comb begin
		freeIdx = '0;
		for (int i = StashPkg::StashSlots - 1; i >= 0; i--) begin
			if (!validVec[i]) begin
				freeIdx = StashPkg::slotIndexT'(i);
			end
		end
	end

	assign anyFree = ~&validVec;
	assign idle = ~PathReadActive & ~WritebackActive;
	assign realBlock = (WritePAddr != '0);

	// Writes only land outside writeback
	assign WriteInReady = (idle | PathReadActive) & anyFree;
	assign accept = WriteInValid & WriteInReady;

	always_comb begin
		loadVec = '0;
		if (accept && realBlock) begin
			loadVec[freeIdx] = 1'b1;
		end
	end

	// ----------------------------------------------------------
	// Status
	// ----------------------------------------------------------

	always_comb begin
		occupancy = '0;
		for (int i = 0; i < StashPkg::StashSlots; i++) begin
			occupancy += {{StashPkg::SlotIndexWidth{1'b0}}, validVec[i]};
		end
	end

	assign StashAlmostFull =
		occupancy >= (StashPkg::SlotIndexWidth + 1)'(StashPkg::AlmostFullMark);

	// Real block offered with nowhere to go
	always_ff @(posedge Clock) begin
		if (reset) begin
			StashOverflow <= 1'b0;
		end else if (WriteInValid && realBlock && !anyFree) begin
			StashOverflow <= 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: verilog/StashControl.sv
/*
 * Access sequencer: idle, path read, then leaf-to-root writeback.
 * StartReadOperation is ignored outside path read.
 */
`default_nettype none

module StashControl (
	input wire Clock,
	input wire reset,
	input wire WriteInValid,
	input wire WriteInReady,
	input wire StartReadOperation,
	input wire BlockSent,
	output logic PathReadActive,
	output logic WritebackActive,
	output StashPkg::levelT Level,
	output logic BlockWriteComplete,
	output logic ReadOutValid
);

	StashPkg::stashStateT state;
	StashPkg::stashStateT stateNext;
	logic writeAccept;

	assign writeAccept = WriteInValid & WriteInReady;

	// ----------------------------------------------------------
	// State machine
	// ----------------------------------------------------------

	always_comb begin
		stateNext = state;
		case (state)
			StashPkg::StIdle:
				if (writeAccept) stateNext = StashPkg::StPathRead;
			StashPkg::StPathRead:
				if (StartReadOperation) stateNext = StashPkg::StWriteback;
			StashPkg::StWriteback:
				// Root bucket sent, access done
				if (BlockSent && Level == '0) stateNext = StashPkg::StIdle;
			default:
				stateNext = StashPkg::StIdle;
		endcase
	end

	always_ff @(posedge Clock) begin
		if (reset) begin
			state <= StashPkg::StIdle;
		end else begin
			state <= stateNext;
		end
	end

	// ----------------------------------------------------------
	// Writeback level counter
	// ----------------------------------------------------------

	// Starts at the leaf bucket, steps toward the root
	always_ff @(posedge Clock) begin
		if (reset) begin
			Level <= '0;
		end else if (state == StashPkg::StPathRead && StartReadOperation) begin
			Level <= StashPkg::levelT'(StashPkg::TreeLevels - 1);
		end else if (state == StashPkg::StWriteback && BlockSent) begin
			Level <= Level - 1'b1;
		end
	end

	// Phase levels and pulses
	assign PathReadActive = (state == StashPkg::StPathRead);
	assign WritebackActive = (state == StashPkg::StWriteback);
	assign ReadOutValid = WritebackActive;
	assign BlockWriteComplete = writeAccept;

endmodule

`default_nettype wire

// File: verilog/StashEvictSelect.sv
/*
 * Picks the block for the current writeback bucket, lowest eligible slot first.
 * Sends a dummy (all zero) when no slot fits. Read fields are combinational.
 */
`default_nettype none

module StashEvictSelect (
	input wire WritebackActive,
	input wire StashPkg::levelT Level,
	input wire StashPkg::leafT AccessLeaf,
	input wire ReadOutValid,
	input wire ReadOutReady,
	output StashPkg::dataT ReadData,
	output StashPkg::pAddrT ReadPAddr,
	output StashPkg::leafT ReadLeaf,
	output logic BlockReadComplete,
	output logic BlockSent,
	StashSlotIf.Drain Drain[StashPkg::StashSlots]
);

	StashPkg::pAddrT slotPAddr[StashPkg::StashSlots];
	StashPkg::leafT slotLeaf[StashPkg::StashSlots];
	StashPkg::dataT slotData[StashPkg::StashSlots];
	logic [StashPkg::StashSlots-1:0] eligible;
	StashPkg::leafT levelMask;
	StashPkg::slotIndexT chosen;
	logic hit;
	logic handshake;

	// ----------------------------------------------------------
	// Eligibility per slot
	// ----------------------------------------------------------

	// Lowest Level bits must match, root level matches everything
	assign levelMask = ~({StashPkg::LeafWidth{1'b1}} << Level);

	assign handshake = WritebackActive & ReadOutValid & ReadOutReady;

	for (genvar i = 0; i < StashPkg::StashSlots; i++) begin : gSlot
		assign slotPAddr[i] = Drain[i].PAddr;
		assign slotLeaf[i] = Drain[i].Leaf;
		assign slotData[i] = Drain[i].Data;
		assign eligible[i] = WritebackActive & Drain[i].Valid &
			(((Drain[i].Leaf ^ AccessLeaf) & levelMask) == '0);
		// Freed at the edge after its handshake
		assign Drain[i].Take = handshake & hit & (chosen == StashPkg::slotIndexT'(i));
	end

	// ----------------------------------------------------------
	// Priority pick
	// ----------------------------------------------------------

	always_comb begin
		hit = 1'b0;
		chosen = '0;
		for (int i = StashPkg::StashSlots - 1; i >= 0; i--) begin
			if (eligible[i]) begin
				hit = 1'b1;
				chosen = StashPkg::slotIndexT'(i);
			end
		end
	end

	// Dummy block when nothing fits
	assign ReadPAddr = hit ? slotPAddr[chosen] : '0;
	assign ReadLeaf = hit ? slotLeaf[chosen] : '0;
	assign ReadData = hit ? slotData[chosen] : '0;

	// ----------------------------------------------------------
	// Completion
	// ----------------------------------------------------------

	assign BlockReadComplete = handshake;
	// Level step for the controller
	assign BlockSent = handshake;

endmodule

`default_nettype wire

// File: verilog/StashPkg.sv
/*
 * Sizes and types for the four-level Path ORAM stash, one block per bucket.
 * Leaf bit 0 picks the root-side branch. Physical address 0 marks a dummy.
 */
`default_nettype none

package StashPkg;

	// ----------------------------------------------------------
	// Tree and stash geometry
	// ----------------------------------------------------------

	// Bucket levels on a path, also blocks per path
	localparam int TreeLevels = 4;
	localparam int LevelWidth = 2;

	localparam int StashSlots = 8;
	localparam int SlotIndexWidth = 3;

	// Occupancy where almost-full rises
	localparam int AlmostFullMark = 6;

	// Block field widths
	localparam int LeafWidth = 4;
	localparam int PAddrWidth = 8;
	localparam int DataWidth = 16;

	// ----------------------------------------------------------
	// Types
	// ----------------------------------------------------------

	typedef logic [LeafWidth-1:0] leafT;
	typedef logic [PAddrWidth-1:0] pAddrT;
	typedef logic [DataWidth-1:0] dataT;
	typedef logic [LevelWidth-1:0] levelT;
	typedef logic [SlotIndexWidth-1:0] slotIndexT;

	// Controller phases
	typedef enum logic [1:0] {
		StIdle,
		StPathRead,
		StWriteback
	} stashStateT;

endpackage

`default_nettype wire

// File: verilog/StashSlot.sv
/*
 * One stash entry. The block is visible on the cycle after Load.
 * Only the valid bit is reset; the stored fields are undefined until filled.
 */
`default_nettype none

module StashSlot (
	input wire Clock,
	input wire reset,
	StashSlotIf.Slot Slot
);

	// ----------------------------------------------------------
	// Occupancy bit
	// ----------------------------------------------------------

	always_ff @(posedge Clock) begin
		if (reset) begin
			Slot.Valid <= 1'b0;
		end else if (Slot.Load) begin
			// New block from the path read
			Slot.Valid <= 1'b1;
		end else if (Slot.Take) begin
			// Block went out during writeback
			Slot.Valid <= 1'b0;
		end
	end

	// ----------------------------------------------------------
	// Block payload
	// ----------------------------------------------------------

	// Captured only on Load, holds through writeback
	always_ff @(posedge Clock) begin
		if (Slot.Load) begin
			Slot.PAddr <= Slot.FillPAddr;
			Slot.Leaf <= Slot.FillLeaf;
			Slot.Data <= Slot.FillData;
		end
	end

endmodule

`default_nettype wire

// File: verilog/StashSlotIf.sv
/*
 * Per-slot link between a stash entry, the allocator and the eviction selector.
 * Load and Take are single-cycle pulses that never hit one slot together.
 */
`default_nettype none

interface StashSlotIf;

	// Stored block, owned by the slot
	logic Valid;
	StashPkg::pAddrT PAddr;
	StashPkg::leafT Leaf;
	StashPkg::dataT Data;

	// Write strobe and fill block from the allocator
	logic Load;
	StashPkg::pAddrT FillPAddr;
	StashPkg::leafT FillLeaf;
	StashPkg::dataT FillData;

	// Free strobe from the selector
	logic Take;

	modport Slot (
		input Load, Take, FillPAddr, FillLeaf, FillData,
		output Valid, PAddr, Leaf, Data
	);

	modport Fill (
		input Valid,
		output Load, FillPAddr, FillLeaf, FillData
	);

	modport Drain (
		input Valid, PAddr, Leaf, Data,
		output Take
	);

endinterface

`default_nettype wire
